// ==== logic/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_CNT_W     = $clog2(BYTES_PER_WORD);
    localparam int REG_COUNT      = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int MEM_WORDS      = 16;
    localparam int MEM_ADDR_W     = 4;
    localparam int IMEM_ADDR_W    = 8;

    localparam logic [BYTE_W-1:0] CMD_CONTINUOUS = 8'h63; // 'c'
    localparam logic [BYTE_W-1:0] CMD_STEP       = 8'h73; // 's'
    localparam logic [BYTE_W-1:0] CMD_NEXT       = 8'h6e; // 'n'
    localparam logic [BYTE_W-1:0] CMD_LOAD       = 8'h72; // 'r'

    localparam logic [WORD_W-1:0] HALT_WORD = '1;

    // pc, cycle count, register file, data memory
    localparam int DUMP_WORDS = 2 + REG_COUNT + MEM_WORDS;
    localparam int DUMP_CNT_W = $clog2(DUMP_WORDS);

    typedef struct packed {
        logic [IMEM_ADDR_W-1:0] addr; // byte address
        logic [WORD_W-1:0]      data;
    } imem_wr_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] reg_sel;
        logic [MEM_ADDR_W-1:0] mem_sel;
    } dump_sel_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_CONT,
        CTRL_STEP,
        CTRL_LOAD,
        CTRL_DUMP
    } ctrl_state_e;

    typedef enum logic [1:0] {
        SRC_PC,
        SRC_CYCLES,
        SRC_REGS,
        SRC_MEM
    } dump_src_e;

endpackage

`default_nettype wire

// ==== logic/instr_loader.sv ====
`default_nettype none

module instr_loader (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_byte_strobe,
    input  wire  [dbg_pkg::BYTE_W-1:0]   i_byte,
    output logic                         o_imem_we,
    output dbg_pkg::imem_wr_t            o_imem_wr,
    output logic                         o_load_done
);

    logic [dbg_pkg::WORD_W-1:0]      word_q;
    logic [dbg_pkg::BYTE_CNT_W-1:0]  byte_cnt_q;
    logic [dbg_pkg::IMEM_ADDR_W-1:0] addr_q;
    logic                            is_halt;

    assign is_halt = (word_q == dbg_pkg::HALT_WORD);

    // msb first, so earlier bytes move up
    always_ff @(posedge i_clk) begin
        if (i_byte_strobe) begin
            word_q <= {word_q[dbg_pkg::WORD_W-dbg_pkg::BYTE_W-1:0], i_byte};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt_q <= '0;
            addr_q     <= '0;
            o_imem_we  <= 1'b0;
        end else begin
            o_imem_we <= 1'b0;
            if (i_byte_strobe) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
                if (byte_cnt_q == dbg_pkg::BYTE_CNT_W'(dbg_pkg::BYTES_PER_WORD - 1)) begin
                    o_imem_we <= 1'b1; // word complete
                end
            end
            if (o_imem_we) begin
                if (is_halt) begin
                    addr_q <= '0; // next load starts over
                end else begin
                    addr_q <= addr_q + dbg_pkg::IMEM_ADDR_W'(dbg_pkg::BYTES_PER_WORD);
                end
            end
        end
    end

    assign o_imem_wr.addr = addr_q;
    assign o_imem_wr.data = word_q;
    assign o_load_done    = o_imem_we && is_halt;

endmodule

`default_nettype wire

// ==== logic/dbg_controller.sv ====
`default_nettype none

module dbg_controller (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire                           i_rx_valid,
    input  wire  [dbg_pkg::BYTE_W-1:0]    i_rx_byte,
    input  wire                           i_halt,
    input  wire                           i_load_done,
    input  wire                           i_dump_done,
    output logic                          o_rx_ack,
    output logic                          o_byte_strobe,
    output logic [dbg_pkg::BYTE_W-1:0]    o_byte,
    output logic                          o_run_en,
    output logic                          o_dump_start
);

    dbg_pkg::ctrl_state_e       state_q;
    logic                       step_flag_q; // return to step mode after a dump
    logic [dbg_pkg::BYTE_W-1:0] byte_q;
    logic                       rx_open;
    logic                       rx_accept;

    // a byte is only taken where it can be used
    always_comb begin
        case (state_q)
            dbg_pkg::CTRL_IDLE: rx_open = 1'b1;
            dbg_pkg::CTRL_LOAD: rx_open = 1'b1;
            dbg_pkg::CTRL_STEP: rx_open = !o_run_en && !i_halt;
            default:            rx_open = 1'b0;
        endcase
    end

    assign rx_accept = i_rx_valid && !o_rx_ack && rx_open;

    always_ff @(posedge i_clk) begin
        if (rx_accept) begin
            byte_q <= i_rx_byte;
        end
    end

    // accepted byte is acted on in the ack cycle
    assign o_byte        = byte_q;
    assign o_byte_strobe = o_rx_ack && (state_q == dbg_pkg::CTRL_LOAD);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q      <= dbg_pkg::CTRL_IDLE;
            step_flag_q  <= 1'b0;
            o_rx_ack     <= 1'b0;
            o_run_en     <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            o_rx_ack     <= rx_accept;
            o_dump_start <= 1'b0;
            case (state_q)
                dbg_pkg::CTRL_IDLE: begin
                    if (o_rx_ack) begin
                        case (byte_q)
                            dbg_pkg::CMD_CONTINUOUS: begin
                                state_q     <= dbg_pkg::CTRL_CONT;
                                step_flag_q <= 1'b0;
                                o_run_en    <= 1'b1;
                            end
                            dbg_pkg::CMD_STEP: begin
                                state_q     <= dbg_pkg::CTRL_STEP;
                                step_flag_q <= 1'b1;
                            end
                            dbg_pkg::CMD_LOAD: begin
                                state_q     <= dbg_pkg::CTRL_LOAD;
                                step_flag_q <= 1'b0;
                            end
                            default: ; // unknown command
                        endcase
                    end
                end
                dbg_pkg::CTRL_CONT: begin
                    if (i_halt) begin
                        o_run_en     <= 1'b0;
                        o_dump_start <= 1'b1;
                        state_q      <= dbg_pkg::CTRL_DUMP;
                    end
                end
                dbg_pkg::CTRL_STEP: begin
                    if (o_run_en) begin // step pulse just went out
                        o_run_en     <= 1'b0;
                        o_dump_start <= 1'b1;
                        state_q      <= dbg_pkg::CTRL_DUMP;
                    end else if (i_halt) begin
                        step_flag_q <= 1'b0;
                        state_q     <= dbg_pkg::CTRL_IDLE;
                    end else if (o_rx_ack && byte_q == dbg_pkg::CMD_NEXT) begin
                        o_run_en <= 1'b1;
                    end
                end
                dbg_pkg::CTRL_LOAD: begin
                    if (i_load_done) begin
                        state_q <= dbg_pkg::CTRL_IDLE;
                    end
                end
                dbg_pkg::CTRL_DUMP: begin
                    if (i_halt) begin
                        step_flag_q <= 1'b0; // core finished during the step
                    end
                    if (i_dump_done) begin
                        if (step_flag_q && !i_halt) begin
                            state_q <= dbg_pkg::CTRL_STEP;
                        end else begin
                            state_q <= dbg_pkg::CTRL_IDLE;
                        end
                    end
                end
                default: state_q <= dbg_pkg::CTRL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/report_sequencer.sv ====
`default_nettype none

module report_sequencer (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_dump_start,
    input  wire  [dbg_pkg::WORD_W-1:0]   i_pc,
    input  wire  [dbg_pkg::WORD_W-1:0]   i_cycles,
    input  wire  [dbg_pkg::WORD_W-1:0]   i_reg_data,
    input  wire  [dbg_pkg::WORD_W-1:0]   i_mem_data,
    input  wire                          i_word_ready,
    output dbg_pkg::dump_sel_t           o_dump_sel,
    output logic                         o_word_valid,
    output logic [dbg_pkg::WORD_W-1:0]   o_word,
    output logic                         o_dump_done
);

    dbg_pkg::dump_src_e              src_q;
    logic                            busy_q;
    logic                            last_q; // every word has been fetched
    logic [dbg_pkg::DUMP_CNT_W-1:0]  word_cnt_q;
    logic                            fetch;

    assign fetch = busy_q && !o_word_valid && !last_q;

    // i_reg_data and i_mem_data already answer the current o_dump_sel
    always_ff @(posedge i_clk) begin
        if (fetch) begin
            case (src_q)
                dbg_pkg::SRC_PC:     o_word <= i_pc;
                dbg_pkg::SRC_CYCLES: o_word <= i_cycles;
                dbg_pkg::SRC_REGS:   o_word <= i_reg_data;
                default:             o_word <= i_mem_data;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            src_q        <= dbg_pkg::SRC_PC;
            busy_q       <= 1'b0;
            last_q       <= 1'b0;
            word_cnt_q   <= '0;
            o_dump_sel   <= '0;
            o_word_valid <= 1'b0;
            o_dump_done  <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;
            if (i_dump_start && !busy_q) begin
                busy_q     <= 1'b1;
                src_q      <= dbg_pkg::SRC_PC;
                word_cnt_q <= '0;
                o_dump_sel <= '0;
            end
            if (fetch) begin
                o_word_valid <= 1'b1;
                word_cnt_q   <= word_cnt_q + 1'b1;
                if (word_cnt_q == dbg_pkg::DUMP_CNT_W'(dbg_pkg::DUMP_WORDS - 1)) begin
                    last_q <= 1'b1;
                end
                case (src_q)
                    dbg_pkg::SRC_PC:     src_q <= dbg_pkg::SRC_CYCLES;
                    dbg_pkg::SRC_CYCLES: src_q <= dbg_pkg::SRC_REGS;
                    dbg_pkg::SRC_REGS: begin
                        if (o_dump_sel.reg_sel ==
                            dbg_pkg::REG_ADDR_W'(dbg_pkg::REG_COUNT - 1)) begin
                            src_q <= dbg_pkg::SRC_MEM;
                        end else begin
                            o_dump_sel.reg_sel <= o_dump_sel.reg_sel + 1'b1;
                        end
                    end
                    default: o_dump_sel.mem_sel <= o_dump_sel.mem_sel + 1'b1;
                endcase
            end
            if (o_word_valid && i_word_ready) begin
                o_word_valid <= 1'b0;
            end
            // serializer empty again means the last byte is out
            if (last_q && !o_word_valid && i_word_ready) begin
                busy_q      <= 1'b0;
                last_q      <= 1'b0;
                o_dump_sel  <= '0;
                o_dump_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/word_serializer.sv ====
`default_nettype none

module word_serializer (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_word_valid,
    input  wire  [dbg_pkg::WORD_W-1:0]   i_word,
    input  wire                          i_tx_idle,
    output logic                         o_word_ready,
    output logic                         o_tx_start,
    output logic [dbg_pkg::BYTE_W-1:0]   o_tx_byte
);

    logic [dbg_pkg::WORD_W-1:0]     shift_q;
    logic [dbg_pkg::BYTE_CNT_W-1:0] byte_cnt_q;
    logic                           full_q;
    logic                           load;
    logic                           next_byte;

    assign o_word_ready = !full_q;
    assign load         = i_word_valid && !full_q;
    // byte done once the transmitter is idle again after start dropped
    assign next_byte    = full_q && !o_tx_start && i_tx_idle;

    always_ff @(posedge i_clk) begin
        if (load) begin
            shift_q <= i_word;
        end else if (next_byte) begin
            shift_q <= shift_q << dbg_pkg::BYTE_W;
        end
    end

    assign o_tx_byte = shift_q[dbg_pkg::WORD_W-1 -: dbg_pkg::BYTE_W];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            full_q     <= 1'b0;
            byte_cnt_q <= '0;
            o_tx_start <= 1'b0;
        end else begin
            if (load) begin
                full_q     <= 1'b1;
                byte_cnt_q <= '0;
                o_tx_start <= 1'b1;
            end else if (o_tx_start) begin
                if (!i_tx_idle) begin
                    o_tx_start <= 1'b0; // transmitter took the byte
                end
            end else if (next_byte) begin
                if (byte_cnt_q == dbg_pkg::BYTE_CNT_W'(dbg_pkg::BYTES_PER_WORD - 1)) begin
                    full_q <= 1'b0;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    o_tx_start <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/debug_unit_top.sv ====
`default_nettype none

module debug_unit_top (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire                           i_rx_valid,
    input  wire  [dbg_pkg::BYTE_W-1:0]    i_rx_byte,
    output logic                          o_rx_ack,
    input  wire                           i_tx_idle,
    output logic                          o_tx_start,
    output logic [dbg_pkg::BYTE_W-1:0]    o_tx_byte,
    input  wire                           i_halt,
    input  wire  [dbg_pkg::WORD_W-1:0]    i_pc,
    input  wire  [dbg_pkg::WORD_W-1:0]    i_cycles,
    input  wire  [dbg_pkg::WORD_W-1:0]    i_reg_data,
    input  wire  [dbg_pkg::WORD_W-1:0]    i_mem_data,
    output logic                          o_run_en,
    output dbg_pkg::dump_sel_t            o_dump_sel,
    output logic                          o_imem_we,
    output dbg_pkg::imem_wr_t             o_imem_wr
);

    logic                       byte_strobe;
    logic [dbg_pkg::BYTE_W-1:0] load_byte;
    logic                       load_done;
    logic                       dump_start;
    logic                       dump_done;
    logic                       word_valid;
    logic                       word_ready;
    logic [dbg_pkg::WORD_W-1:0] word;

    dbg_controller u_ctrl (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_rx_valid    (i_rx_valid),
        .i_rx_byte     (i_rx_byte),
        .i_halt        (i_halt),
        .i_load_done   (load_done),
        .i_dump_done   (dump_done),
        .o_rx_ack      (o_rx_ack),
        .o_byte_strobe (byte_strobe),
        .o_byte        (load_byte),
        .o_run_en      (o_run_en),
        .o_dump_start  (dump_start)
    );

    instr_loader u_loader (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_byte_strobe (byte_strobe),
        .i_byte        (load_byte),
        .o_imem_we     (o_imem_we),
        .o_imem_wr     (o_imem_wr),
        .o_load_done   (load_done)
    );

    report_sequencer u_seq (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_dump_start (dump_start),
        .i_pc         (i_pc),
        .i_cycles     (i_cycles),
        .i_reg_data   (i_reg_data),
        .i_mem_data   (i_mem_data),
        .i_word_ready (word_ready),
        .o_dump_sel   (o_dump_sel),
        .o_word_valid (word_valid),
        .o_word       (word),
        .o_dump_done  (dump_done)
    );

    word_serializer u_ser (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_word_valid (word_valid),
        .i_word       (word),
        .i_tx_idle    (i_tx_idle),
        .o_word_ready (word_ready),
        .o_tx_start   (o_tx_start),
        .o_tx_byte    (o_tx_byte)
    );

endmodule

`default_nettype wire

// ==== dv/debug_ref.svh ====
`ifndef DEBUG_REF_SVH
`define DEBUG_REF_SVH

// register file and data memory of the modeled core
logic [dbg_pkg::WORD_W-1:0] reg_model [dbg_pkg::REG_COUNT];
logic [dbg_pkg::WORD_W-1:0] mem_model [dbg_pkg::MEM_WORDS];

function automatic void fill_models(input logic [31:0] reg_base, input logic [31:0] mem_base);
    for (int i = 0; i < dbg_pkg::REG_COUNT; i++) begin
        reg_model[dbg_pkg::REG_ADDR_W'(i)] = reg_base + 32'(i) * 32'h9e37_79b9;
    end
    for (int i = 0; i < dbg_pkg::MEM_WORDS; i++) begin
        mem_model[dbg_pkg::MEM_ADDR_W'(i)] = mem_base ^ (32'(i) * 32'h0101_0101 + 32'(i << 28));
    end
endfunction

// dump order is pc, cycles, registers, memory, each word msb first
function automatic logic [7:0] dump_byte(input int idx, input logic [31:0] pc,
                                         input logic [31:0] cycles);
    int          w;
    logic [31:0] word;
    w = idx / dbg_pkg::BYTES_PER_WORD;
    if (w == 0) begin
        word = pc;
    end else if (w == 1) begin
        word = cycles;
    end else if (w < 2 + dbg_pkg::REG_COUNT) begin
        word = reg_model[dbg_pkg::REG_ADDR_W'(w - 2)];
    end else begin
        word = mem_model[dbg_pkg::MEM_ADDR_W'(w - 2 - dbg_pkg::REG_COUNT)];
    end
    return 8'(word >> (24 - 8 * (idx % dbg_pkg::BYTES_PER_WORD)));
endfunction

`endif

// ==== dv/tb_debug_unit.sv ====
`default_nettype none

module tb_debug_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DUMPS  = 5;
    localparam int DUMP_BYTES = dbg_pkg::DUMP_WORDS * dbg_pkg::BYTES_PER_WORD;
    localparam int CMD_BYTES  = 60; // load words and command bytes
    localparam longint LIMIT_NS = 2 * ((NUM_DUMPS * DUMP_BYTES + CMD_BYTES) * (8 + 6) + 400) * 20;

    logic               i_clk = 1'b0;
    logic               i_reset, i_rx_valid, i_tx_idle, i_halt;
    logic [7:0]         i_rx_byte;
    logic [31:0]        i_pc, i_cycles, i_reg_data, i_mem_data;
    logic               o_rx_ack, o_tx_start, o_run_en, o_imem_we;
    logic [7:0]         o_tx_byte;
    dbg_pkg::dump_sel_t o_dump_sel;
    dbg_pkg::imem_wr_t  o_imem_wr;
    logic               target_armed, halt_force;
    logic [31:0]        halt_target, exp_pc, exp_cycles;
    logic [7:0]         tx_bytes[$], exp_bytes[$], wr_addrs[$];
    logic [31:0]        wr_words[$];
    int                 run_count = 0, we_count = 0, tx_count = 0, busy_cnt;
    int                 value_errors = 0, other_errors = 0;

    `include "debug_ref.svh"

    always #10 i_clk = ~i_clk;

    assign i_reg_data = reg_model[o_dump_sel.reg_sel];
    assign i_mem_data = mem_model[o_dump_sel.mem_sel];

    debug_unit_top dut0 (.*);

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    initial begin
        i_tx_idle = 1'b1;
        forever begin
            @(posedge i_clk);
            if (!i_tx_idle) begin
                busy_cnt--;
                if (busy_cnt == 0) i_tx_idle <= 1'b1;
            end else if (o_tx_start && !i_reset) begin
                tx_bytes.push_back(o_tx_byte);
                tx_count++;
                busy_cnt = $urandom_range(8, 1);
                i_tx_idle <= 1'b0;
            end
        end
    end

    initial begin
        i_pc     = '0;
        i_cycles = '0;
        i_halt   = 1'b0;
        forever begin
            @(posedge i_clk);
            if (o_run_en && !i_halt) begin
                i_pc     <= i_pc + 32'd4;
                i_cycles <= i_cycles + 32'd1;
                i_halt   <= halt_force || (target_armed && i_pc + 32'd4 == halt_target);
            end else begin
                i_halt <= halt_force || (target_armed && i_halt); // core stays halted
            end
        end
    end

    always @(posedge i_clk) begin
        if (o_run_en) run_count++;
        if (o_imem_we) begin
            we_count++;
            if (wr_words.size() == 0) begin
                other_errors++;
                $display("%0t ns: instruction-memory write with none expected", $time);
            end else begin
                check_value("o_imem_wr.addr", 32'(o_imem_wr.addr), 32'(wr_addrs.pop_front()));
                check_value("o_imem_wr.data", o_imem_wr.data, wr_words.pop_front());
            end
        end
    end

    initial begin
        logic [7:0] got;
        forever begin
            @(posedge i_clk);
            while (tx_bytes.size() != 0) begin
                got = tx_bytes.pop_front();
                if (exp_bytes.size() == 0) begin
                    other_errors++;
                    $display("%0t ns: extra transmit byte 0x%h", $time, got);
                end else begin
                    check_value("o_tx_byte", 32'(got), 32'(exp_bytes.pop_front()));
                end
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout after %0d ns, the run did not complete", LIMIT_NS);
        $display("Test FAILED");
        $finish;
    end

    task automatic send_byte(input logic [7:0] b);
        @(posedge i_clk);
        i_rx_valid <= 1'b1;
        i_rx_byte  <= b;
        do begin
            @(posedge i_clk);
        end while (!o_rx_ack);
        i_rx_valid <= 1'b0;
        @(posedge i_clk);
        check_value("o_rx_ack", 32'(o_rx_ack), 0); // ack is a single-cycle pulse
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            send_byte(8'(w >> (24 - 8 * i)));
        end
    endtask

    // last byte checked and the transmitter idle again
    task automatic wait_dump();
        while (exp_bytes.size() != 0 || !i_tx_idle) begin
            @(posedge i_clk);
        end
        repeat (3) @(posedge i_clk);
    endtask

    task automatic expect_dump();
        fill_models($urandom, $urandom);
        for (int k = 0; k < DUMP_BYTES; k++) begin
            exp_bytes.push_back(dump_byte(k, exp_pc, exp_cycles));
        end
    endtask

    task automatic expect_ignored(input logic [7:0] b);
        int runs;
        int writes;
        int sent;
        runs   = run_count;
        writes = we_count;
        sent   = tx_count;
        send_byte(b);
        repeat (8) @(posedge i_clk);
        check_value("o_run_en cycles", 32'(run_count - runs), 0);
        check_value("o_imem_we pulses", 32'(we_count - writes), 0);
        check_value("tx bytes", 32'(tx_count - sent), 0);
    endtask

    task automatic load_program(input int words);
        logic [31:0] w;
        send_byte(dbg_pkg::CMD_LOAD);
        for (int i = 0; i <= words; i++) begin
            w = (i == words) ? dbg_pkg::HALT_WORD : $urandom;
            if (i < words && w == dbg_pkg::HALT_WORD) w = 32'h0;
            wr_addrs.push_back(8'(4 * i));
            wr_words.push_back(w);
            send_word(w);
        end
        while (wr_words.size() != 0) @(posedge i_clk);
        @(posedge i_clk);
    endtask

    task automatic run_continuous(input int steps);
        int runs;
        runs = run_count;
        halt_target  <= exp_pc + 32'(4 * steps);
        target_armed <= 1'b1;
        exp_pc     = exp_pc + 32'(4 * steps);
        exp_cycles = exp_cycles + 32'(steps);
        expect_dump();
        send_byte(dbg_pkg::CMD_CONTINUOUS);
        wait_dump();
        // enable is still up in the cycle the halt is seen
        check_value("o_run_en cycles", 32'(run_count - runs), 32'(steps + 1));
        target_armed <= 1'b0;
        repeat (2) @(posedge i_clk);
    endtask

    task automatic step_once();
        int runs;
        runs = run_count;
        exp_pc     = exp_pc + 32'd4;
        exp_cycles = exp_cycles + 32'd1;
        expect_dump();
        send_byte(dbg_pkg::CMD_NEXT);
        wait_dump();
        check_value("o_run_en cycles per step", 32'(run_count - runs), 32'd1);
    endtask

    initial begin
        int unsigned seed;
        seed         = $urandom(32'hdae7);
        i_reset      = 1'b1;
        i_rx_valid   = 1'b0;
        i_rx_byte    = '0;
        halt_force   = 1'b0;
        target_armed = 1'b0;
        halt_target  = '0;
        exp_pc       = '0;
        exp_cycles   = '0;
        fill_models(seed, ~seed);
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (10) @(posedge i_clk);
        check_value("o_run_en cycles", 32'(run_count), 0);
        check_value("o_imem_we pulses", 32'(we_count), 0);
        check_value("tx bytes", 32'(tx_count), 0);
        check_value("o_dump_sel", 32'(o_dump_sel), 0);
        load_program(6);
        load_program(3); // must start over at address 0
        expect_ignored(8'h78);
        expect_ignored(8'h00);
        run_continuous($urandom_range(40, 5));
        send_byte(dbg_pkg::CMD_STEP);
        step_once();
        expect_ignored(dbg_pkg::CMD_CONTINUOUS);
        expect_ignored(dbg_pkg::CMD_LOAD);
        step_once();
        step_once();
        halt_force <= 1'b1; // halt in step mode returns to idle
        repeat (3) @(posedge i_clk);
        halt_force <= 1'b0;
        repeat (3) @(posedge i_clk);
        run_continuous($urandom_range(40, 5));
        repeat (20) @(posedge i_clk);
        check_value("tx bytes", 32'(tx_count), 32'(NUM_DUMPS * DUMP_BYTES));
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_debug_unit.f ====
+incdir+dv
logic/dbg_pkg.sv
logic/instr_loader.sv
logic/dbg_controller.sv
logic/report_sequencer.sv
logic/word_serializer.sv
logic/debug_unit_top.sv
dv/tb_debug_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_debug_unit -f mips_debug_unit.f -o sim_debug_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_debug_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
